/* tb/mem_vectors.txt */
# name inst src1 src2 exp_res (all hex)
# then exp_wb and exp_err flags
sd_init   0020b023 0000000000000010 1122334455667788 0000000000000000 0 0
sw_merge  0020a023 0000000000000010 ffffffffa1a2a3a4 0000000000000000 0 0
sh_merge  00209023 0000000000000010 ffffffffffffb1b2 0000000000000000 0 0
sb_merge  00208023 0000000000000010 ffffffffffffffc1 0000000000000000 0 0
ld_merge  0000b283 0000000000000010 0000000000000000 11223344a1a2b1c1 1 0
sd_sign   0020b023 0000000000000020 0123456789abcdef 0000000000000000 0 0
lb_sign   00008283 0000000000000020 0000000000000000 ffffffffffffffef 1 0
lh_sign   00009283 0000000000000020 0000000000000000 ffffffffffffcdef 1 0
lw_sign   0000a283 0000000000000020 0000000000000000 ffffffff89abcdef 1 0
lbu_zero  0000c283 0000000000000020 0000000000000000 00000000000000ef 1 0
lhu_zero  0000d283 0000000000000020 0000000000000000 000000000000cdef 1 0
lwu_zero  0000e283 0000000000000020 0000000000000000 0000000089abcdef 1 0
sd_neg    fe20bc23 0000000000000038 cafef00d12345678 0000000000000000 0 0
ld_pos    00b0b283 0000000000000025 0000000000000000 cafef00d12345678 1 0
st_bad    0020c023 0000000000000030 ffffffffffffffff 0000000000000000 0 1
op_bad    00508093 0000000000000030 0000000000000000 0000000000000000 0 1
ld_bad    0000f283 0000000000000030 0000000000000000 0000000000000000 0 1
ld_neg    ff00b283 0000000000000040 0000000000000000 cafef00d12345678 1 0
ld_unmap  0000b283 0000000000000090 0000000000000000 cafef00d12345678 0 1
ld_after  0000b283 0000000000000020 0000000000000000 0123456789abcdef 1 0

/* verilog.f */
hdl/secv_pkg.sv
hdl/mem_funit.sv
hdl/mem_issue_fsm.sv
hdl/bus_watchdog.sv
hdl/dmem_ram.sv
hdl/secv_mem_top.sv
tb/tb_secv_mem.sv

/* Bender.yml */
package:
  name: secv_mem

sources:
  - hdl/secv_pkg.sv
  - hdl/mem_funit.sv
  - hdl/mem_issue_fsm.sv
  - hdl/bus_watchdog.sv
  - hdl/dmem_ram.sv
  - hdl/secv_mem_top.sv
  - target: simulation
    files:
      - tb/tb_secv_mem.sv

/* tb/tb_secv_mem.sv */
// Vector-driven testbench that runs as the simulation top of the data-memory path
`timescale 1ns/1ps
`default_nettype none

module tb_secv_mem;
    import secv_pkg::*;

    localparam int CLK_HALF_NS  = 2;
    localparam int RESET_CYCLES = 2;
    localparam int WAIT_LIMIT   = 100;
    localparam int NAME_CHARS   = 32;
    localparam int LINE_CHARS   = 128;

    logic            clk;
    logic            rst_n;
    logic            req;
    inst_t           inst;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            busy;
    logic            done;
    logic [XLEN-1:0] res;
    logic            res_wb;
    logic            err;

    int   error_cnt;
    int   test_cnt;
    int   test_fail_cnt;
    logic timed_out;

    secv_mem_top i_secv_mem_top (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .req_i    (req),
        .inst_i   (inst),
        .src1_i   (src1),
        .src2_i   (src2),
        .busy_o   (busy),
        .done_o   (done),
        .res_o    (res),
        .res_wb_o (res_wb),
        .err_o    (err)
    );

    always #CLK_HALF_NS clk = ~clk;

    task automatic check_value(
        input logic [8*NAME_CHARS-1:0] test_name,
        input logic [8*8-1:0]          field,
        input logic [XLEN-1:0]         expected,
        input logic [XLEN-1:0]         actual
    );
        if (actual !== expected) begin
            error_cnt++;
            $display("** Error %0s %0s: expected %h, actual %h",
                     test_name, field, expected, actual);
        end
    endtask

    // Outputs are sampled on the falling edge away from the DUT updates
    task automatic wait_idle(output logic ok);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = !busy;
    endtask

    task automatic wait_done(output logic ok);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = done;
    endtask

    // One-cycle request strobe
    task automatic issue_request(
        input logic [31:0]     t_inst,
        input logic [XLEN-1:0] t_src1,
        input logic [XLEN-1:0] t_src2
    );
        @(posedge clk);
        req  <= 1'b1;
        inst <= t_inst;
        src1 <= t_src1;
        src2 <= t_src2;
        @(posedge clk);
        req  <= 1'b0;
    endtask

    task automatic run_test(
        input logic [8*NAME_CHARS-1:0] test_name,
        input logic [31:0]             t_inst,
        input logic [XLEN-1:0]         t_src1,
        input logic [XLEN-1:0]         t_src2,
        input logic [XLEN-1:0]         exp_res,
        input logic [XLEN-1:0]         exp_wb,
        input logic [XLEN-1:0]         exp_err
    );
        logic ok;
        int   errors_before;
        errors_before = error_cnt;
        test_cnt++;
        wait_idle(ok);
        if (!ok) begin
            $display("Test %0s: DUT still busy after %0d cycles, request not sent",
                     test_name, WAIT_LIMIT);
            timed_out = 1'b1;
        end else begin
            issue_request(t_inst, t_src1, t_src2);
            // An accepted request holds the sequencer busy
            @(negedge clk);
            check_value(test_name, "busy", XLEN'(1), XLEN'(busy));
            wait_done(ok);
            if (!ok) begin
                $display("Test %0s: no done pulse within %0d cycles", test_name, WAIT_LIMIT);
                timed_out = 1'b1;
            end else begin
                // The result is only defined for a load that writes back
                if (exp_wb != '0) begin
                    check_value(test_name, "res", exp_res, res);
                end
                check_value(test_name, "res_wb", exp_wb, XLEN'(res_wb));
                check_value(test_name, "err", exp_err, XLEN'(err));
            end
        end
        if (timed_out || error_cnt != errors_before) begin
            test_fail_cnt++;
            $display("FAIL %0s", test_name);
        end else begin
            $display("PASS %0s", test_name);
        end
    endtask

    initial begin
        int                      fd;
        int                      code;
        logic                    stop;
        logic [8*NAME_CHARS-1:0] test_name;
        logic [8*LINE_CHARS-1:0] rest;
        logic [31:0]             vec_inst;
        logic [XLEN-1:0]         vec_src1;
        logic [XLEN-1:0]         vec_src2;
        logic [XLEN-1:0]         vec_res;
        logic [XLEN-1:0]         vec_wb;
        logic [XLEN-1:0]         vec_err;

        clk           = 1'b0;
        rst_n         = 1'b0;
        req           = 1'b0;
        inst          = '0;
        src1          = '0;
        src2          = '0;
        error_cnt     = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        timed_out     = 1'b0;
        stop          = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("tb/mem_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tb/mem_vectors.txt");
            error_cnt++;
        end else begin
            while (!stop) begin
                code = $fscanf(fd, " %s", test_name);
                if (code != 1) begin
                    stop = 1'b1;
                end else if (test_name == "#") begin
                    // Comment line whose rest is skipped
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, " %h %h %h %h %h %h",
                                   vec_inst, vec_src1, vec_src2, vec_res, vec_wb, vec_err);
                    if (code != 6) begin
                        $display("Vector line of test %0s is incomplete", test_name);
                        error_cnt++;
                        stop = 1'b1;
                    end else begin
                        run_test(test_name, vec_inst, vec_src1, vec_src2,
                                 vec_res, vec_wb, vec_err);
                        if (timed_out) begin
                            stop = 1'b1;
                        end
                    end
                end
            end
            $fclose(fd);
            if (test_cnt == 0) begin
                $display("The vector file held no tests");
                error_cnt++;
            end
        end

        $display("Tests run: %0d, tests failed: %0d, mismatches: %0d",
                 test_cnt, test_fail_cnt, error_cnt);
        if (error_cnt == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/secv_mem_top.sv */
// Top of the data-memory path: sequencer, load/store unit, bus watchdog and data RAM
`timescale 1ns/1ps
`default_nettype none

module secv_mem_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         req_i,
    input  secv_pkg::inst_t              inst_i,
    input  logic [secv_pkg::XLEN-1:0]    src1_i,
    input  logic [secv_pkg::XLEN-1:0]    src2_i,
    output logic                         busy_o,
    output logic                         done_o,
    output logic [secv_pkg::XLEN-1:0]    res_o,
    output logic                         res_wb_o,
    output logic                         err_o
);
    import secv_pkg::*;

    // Sequencer to function unit
    logic                   fu_ena;
    inst_t                  fu_inst;
    logic [XLEN-1:0]        fu_src1;
    logic [XLEN-1:0]        fu_src2;
    logic                   fu_rdy;
    logic                   fu_err;
    logic [XLEN-1:0]        fu_res;
    logic                   fu_res_wb;

    // Wishbone data bus
    logic                   dmem_cyc;
    logic                   dmem_stb;
    logic                   dmem_we;
    logic [SEL_WIDTH-1:0]   dmem_sel;
    logic [ADR_WIDTH-1:0]   dmem_adr;
    logic [XLEN-1:0]        dmem_dat_w;
    logic [XLEN-1:0]        dmem_dat_r;
    logic                   dmem_ack;
    logic                   bus_timeout;

    mem_issue_fsm i_mem_issue_fsm (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .inst_i      (inst_i),
        .src1_i      (src1_i),
        .src2_i      (src2_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .fu_ena_o    (fu_ena),
        .fu_inst_o   (fu_inst),
        .fu_src1_o   (fu_src1),
        .fu_src2_o   (fu_src2),
        .fu_rdy_i    (fu_rdy),
        .fu_err_i    (fu_err),
        .fu_res_i    (fu_res),
        .fu_res_wb_i (fu_res_wb),
        .res_o       (res_o),
        .res_wb_o    (res_wb_o),
        .err_o       (err_o)
    );

    mem_funit i_mem_funit (
        .ena_i         (fu_ena),
        .inst_i        (fu_inst),
        .src1_i        (fu_src1),
        .src2_i        (fu_src2),
        .rdy_o         (fu_rdy),
        .err_o         (fu_err),
        .res_o         (fu_res),
        .res_wb_o      (fu_res_wb),
        .dmem_cyc_o    (dmem_cyc),
        .dmem_stb_o    (dmem_stb),
        .dmem_sel_o    (dmem_sel),
        .dmem_adr_o    (dmem_adr),
        .dmem_we_o     (dmem_we),
        .dmem_dat_o    (dmem_dat_w),
        .dmem_dat_i    (dmem_dat_r),
        .dmem_ack_i    (dmem_ack),
        .bus_timeout_i (bus_timeout)
    );

    bus_watchdog i_bus_watchdog (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .cyc_i     (dmem_cyc),
        .ack_i     (dmem_ack),
        .timeout_o (bus_timeout)
    );

    dmem_ram i_dmem_ram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (dmem_cyc),
        .stb_i   (dmem_stb),
        .we_i    (dmem_we),
        .sel_i   (dmem_sel),
        .adr_i   (dmem_adr),
        .dat_i   (dmem_dat_w),
        .dat_o   (dmem_dat_r),
        .ack_o   (dmem_ack)
    );

endmodule

`default_nettype wire

/* hdl/dmem_ram.sv */
// Data RAM as a Wishbone-classic slave with byte-select writes and a registered acknowledge
`timescale 1ns/1ps
`default_nettype none

module dmem_ram (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             cyc_i,
    input  logic                             stb_i,
    input  logic                             we_i,
    input  logic [secv_pkg::SEL_WIDTH-1:0]   sel_i,
    input  logic [secv_pkg::ADR_WIDTH-1:0]   adr_i,
    input  logic [secv_pkg::XLEN-1:0]        dat_i,
    output logic [secv_pkg::XLEN-1:0]        dat_o,
    output logic                             ack_o
);
    import secv_pkg::*;

    logic [XLEN-1:0]           mem_q [DMEM_DEPTH];
    logic [DMEM_IDX_WIDTH-1:0] idx;
    logic                      mapped;
    logic                      access;

    assign idx    = adr_i[DMEM_IDX_WIDTH-1:0];
    assign mapped = (adr_i < ADR_WIDTH'(DMEM_DEPTH));

    // Blocked while acknowledging so that no ack comes back to back
    assign access = cyc_i && stb_i && mapped && !ack_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access && we_i) begin
            for (int b = 0; b < SEL_WIDTH; b++) begin
                if (sel_i[b]) begin
                    mem_q[idx][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
        if (access) begin
            dat_o <= mem_q[idx];
        end
    end

    a_ack_in_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> stb_i)
        else $error("acknowledge outside a strobe");

endmodule

`default_nettype wire

/* hdl/bus_watchdog.sv */
// Bus watchdog: counts cycles without acknowledge and flags a timeout to end a stuck access
`timescale 1ns/1ps
`default_nettype none

module bus_watchdog (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic cyc_i,
    input  logic ack_i,
    output logic timeout_o
);
    import secv_pkg::*;

    logic [WDOG_CNT_WIDTH-1:0] wait_cnt_q;

    // Saturates at the limit until the cycle drops
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wait_cnt_q <= '0;
        end else if (!cyc_i || ack_i) begin
            wait_cnt_q <= '0;
        end else if (!timeout_o) begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end
    end

    assign timeout_o = (wait_cnt_q == WDOG_CNT_WIDTH'(ACK_TIMEOUT));

endmodule

`default_nettype wire

/* hdl/mem_issue_fsm.sv */
// Issue sequencer that holds one load/store request and registers the function unit's result
`timescale 1ns/1ps
`default_nettype none

module mem_issue_fsm (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         req_i,
    input  secv_pkg::inst_t              inst_i,
    input  logic [secv_pkg::XLEN-1:0]    src1_i,
    input  logic [secv_pkg::XLEN-1:0]    src2_i,
    output logic                         busy_o,
    output logic                         done_o,

    output logic                         fu_ena_o,
    output secv_pkg::inst_t              fu_inst_o,
    output logic [secv_pkg::XLEN-1:0]    fu_src1_o,
    output logic [secv_pkg::XLEN-1:0]    fu_src2_o,
    input  logic                         fu_rdy_i,
    input  logic                         fu_err_i,
    input  logic [secv_pkg::XLEN-1:0]    fu_res_i,
    input  logic                         fu_res_wb_i,

    output logic [secv_pkg::XLEN-1:0]    res_o,
    output logic                         res_wb_o,
    output logic                         err_o
);
    import secv_pkg::*;

    logic [1:0] state_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= FSM_IDLE;
            res_wb_o <= 1'b0;
            err_o    <= 1'b0;
        end else begin
            case (state_q)
                FSM_IDLE: begin
                    if (req_i) begin
                        state_q <= FSM_ACCESS;
                    end
                end
                FSM_ACCESS: begin
                    if (fu_rdy_i) begin
                        state_q  <= FSM_DONE;
                        res_wb_o <= fu_res_wb_i;
                        err_o    <= fu_err_i;
                    end
                end
                default: state_q <= FSM_IDLE;
            endcase
        end
    end

    // Operands and result payload
    always_ff @(posedge clk_i) begin
        if (state_q == FSM_IDLE && req_i) begin
            fu_inst_o <= inst_i;
            fu_src1_o <= src1_i;
            fu_src2_o <= src2_i;
        end
        if (state_q == FSM_ACCESS && fu_rdy_i) begin
            res_o <= fu_res_i;
        end
    end

    assign fu_ena_o = (state_q == FSM_ACCESS);
    assign busy_o   = (state_q != FSM_IDLE);
    assign done_o   = (state_q == FSM_DONE);

    a_wb_not_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_o |-> !(res_wb_o && err_o))
        else $error("result both written back and flagged as an error");

endmodule

`default_nettype wire

/* hdl/mem_funit.sv */
// Load/store function unit that decodes accesses and drives the Wishbone bus to the data RAM
`timescale 1ns/1ps
`default_nettype none

module mem_funit (
    input  logic                             ena_i,
    input  secv_pkg::inst_t                  inst_i,
    input  logic [secv_pkg::XLEN-1:0]        src1_i,
    input  logic [secv_pkg::XLEN-1:0]        src2_i,
    output logic                             rdy_o,
    output logic                             err_o,
    output logic [secv_pkg::XLEN-1:0]        res_o,
    output logic                             res_wb_o,

    output logic                             dmem_cyc_o,
    output logic                             dmem_stb_o,
    output logic [secv_pkg::SEL_WIDTH-1:0]   dmem_sel_o,
    output logic [secv_pkg::ADR_WIDTH-1:0]   dmem_adr_o,
    output logic                             dmem_we_o,
    output logic [secv_pkg::XLEN-1:0]        dmem_dat_o,
    input  logic [secv_pkg::XLEN-1:0]        dmem_dat_i,
    input  logic                             dmem_ack_i,
    input  logic                             bus_timeout_i
);
    import secv_pkg::*;

    opcode_t                opcode;
    funct3_t                funct3;
    logic                   is_load;
    logic                   is_store;
    logic                   dec_err;
    logic                   bus_act;
    logic [XLEN-1:0]        imm;
    logic [XLEN-1:0]        eff_adr;
    logic [SEL_WIDTH-1:0]   sel;
    logic [XLEN-1:0]        st_dat;
    logic [XLEN-1:0]        ld_dat;

    assign opcode   = inst_i.r_type.opcode;
    assign funct3   = inst_i.r_type.funct3;
    assign is_load  = (opcode == OPCODE_LOAD);
    assign is_store = (opcode == OPCODE_STORE);

    // I-type immediate for loads, split S-type immediate for stores
    always_comb begin
        if (is_store) begin
            imm = {{(XLEN-12){inst_i.s_type.imm_hi[6]}},
                   inst_i.s_type.imm_hi, inst_i.s_type.imm_lo};
        end else begin
            imm = {{(XLEN-12){inst_i.i_type.imm[11]}}, inst_i.i_type.imm};
        end
    end

    // Word address with no byte offset kept
    assign eff_adr = src1_i + imm;

    // Width decode with the data always in the low bytes of the word
    always_comb begin
        dec_err = 1'b0;
        sel     = '0;
        st_dat  = '0;
        ld_dat  = '0;
        if (is_load) begin
            case (funct3)
                FUNCT3_LOAD_LB: begin
                    sel    = 8'h01;
                    ld_dat = {{(XLEN-8){dmem_dat_i[7]}}, dmem_dat_i[7:0]};
                end
                FUNCT3_LOAD_LH: begin
                    sel    = 8'h03;
                    ld_dat = {{(XLEN-16){dmem_dat_i[15]}}, dmem_dat_i[15:0]};
                end
                FUNCT3_LOAD_LW: begin
                    sel    = 8'h0f;
                    ld_dat = {{(XLEN-32){dmem_dat_i[31]}}, dmem_dat_i[31:0]};
                end
                FUNCT3_LOAD_LD: begin
                    sel    = 8'hff;
                    ld_dat = dmem_dat_i;
                end
                FUNCT3_LOAD_LBU: begin
                    sel         = 8'h01;
                    ld_dat[7:0] = dmem_dat_i[7:0];
                end
                FUNCT3_LOAD_LHU: begin
                    sel          = 8'h03;
                    ld_dat[15:0] = dmem_dat_i[15:0];
                end
                FUNCT3_LOAD_LWU: begin
                    sel          = 8'h0f;
                    ld_dat[31:0] = dmem_dat_i[31:0];
                end
                default: dec_err = 1'b1;
            endcase
        end else if (is_store) begin
            case (funct3)
                FUNCT3_STORE_SB: begin
                    sel         = 8'h01;
                    st_dat[7:0] = src2_i[7:0];
                end
                FUNCT3_STORE_SH: begin
                    sel          = 8'h03;
                    st_dat[15:0] = src2_i[15:0];
                end
                FUNCT3_STORE_SW: begin
                    sel          = 8'h0f;
                    st_dat[31:0] = src2_i[31:0];
                end
                FUNCT3_STORE_SD: begin
                    sel    = 8'hff;
                    st_dat = src2_i;
                end
                default: dec_err = 1'b1;
            endcase
        end else begin
            dec_err = 1'b1;
        end
    end

    // Bus stays idle on a decode error
    assign bus_act    = ena_i && !dec_err;
    assign dmem_cyc_o = bus_act;
    assign dmem_stb_o = bus_act;
    assign dmem_we_o  = bus_act && is_store;
    assign dmem_sel_o = bus_act ? sel : '0;
    assign dmem_adr_o = bus_act ? eff_adr[ADR_WIDTH-1:0] : '0;
    assign dmem_dat_o = bus_act ? st_dat : '0;

    // Acknowledge wins over a timeout in the same cycle
    assign rdy_o    = ena_i && (dec_err || dmem_ack_i || bus_timeout_i);
    assign err_o    = ena_i && (dec_err || (bus_timeout_i && !dmem_ack_i));
    assign res_wb_o = bus_act && is_load && dmem_ack_i;
    assign res_o    = (ena_i && is_load) ? ld_dat : '0;

endmodule

`default_nettype wire

/* hdl/secv_pkg.sv */
// Shared sizes, opcode codes and instruction layouts for the data-memory path, imported by all RTL
`default_nettype none

package secv_pkg;

    // Data and bus sizes
    localparam int XLEN      = 64;
    localparam int SEL_WIDTH = XLEN / 8;
    localparam int ADR_WIDTH = 8;

    // Words mapped by the data RAM
    localparam int DMEM_DEPTH     = 128;
    localparam int DMEM_IDX_WIDTH = $clog2(DMEM_DEPTH);

    // Waiting cycles before an access is abandoned
    localparam int ACK_TIMEOUT    = 12;
    localparam int WDOG_CNT_WIDTH = $clog2(ACK_TIMEOUT + 1);

    // Issue sequencer states
    localparam logic [1:0] FSM_IDLE   = 2'd0;
    localparam logic [1:0] FSM_ACCESS = 2'd1;
    localparam logic [1:0] FSM_DONE   = 2'd2;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // Major opcodes
    localparam opcode_t OPCODE_LOAD  = 7'b000_0011;
    localparam opcode_t OPCODE_STORE = 7'b010_0011;

    // Load widths
    localparam funct3_t FUNCT3_LOAD_LB  = 3'b000;
    localparam funct3_t FUNCT3_LOAD_LH  = 3'b001;
    localparam funct3_t FUNCT3_LOAD_LW  = 3'b010;
    localparam funct3_t FUNCT3_LOAD_LD  = 3'b011;
    localparam funct3_t FUNCT3_LOAD_LBU = 3'b100;
    localparam funct3_t FUNCT3_LOAD_LHU = 3'b101;
    localparam funct3_t FUNCT3_LOAD_LWU = 3'b110;

    // Store widths
    localparam funct3_t FUNCT3_STORE_SB = 3'b000;
    localparam funct3_t FUNCT3_STORE_SH = 3'b001;
    localparam funct3_t FUNCT3_STORE_SW = 3'b010;
    localparam funct3_t FUNCT3_STORE_SD = 3'b011;

    // One instruction word, viewed in the layout its opcode calls for
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            funct3_t    funct3;
            logic [4:0] rd;
            opcode_t    opcode;
        } r_type;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            funct3_t     funct3;
            logic [4:0]  rd;
            opcode_t     opcode;
        } i_type;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            funct3_t    funct3;
            logic [4:0] imm_lo;
            opcode_t    opcode;
        } s_type;
    } inst_t;

endpackage

`default_nettype wire
